/* hdl/dwb_pkg.sv */
`default_nettype none

package dwb_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;

  ////////////////////////////////////////////////////////////
  // Region table and configuration port
  ////////////////////////////////////////////////////////////
  localparam int NUM_REGIONS = 2;
  localparam int CFG_ADDR_W  = 3;
  // Stored attribute bits per region
  localparam int ATTR_W      = 2;

  // Word offsets on the configuration port, 6 and 7 unused
  localparam logic [CFG_ADDR_W-1:0] REG_BASE0 = 3'd0;
  localparam logic [CFG_ADDR_W-1:0] REG_MASK0 = 3'd1;
  localparam logic [CFG_ADDR_W-1:0] REG_ATTR0 = 3'd2;
  localparam logic [CFG_ADDR_W-1:0] REG_BASE1 = 3'd3;
  localparam logic [CFG_ADDR_W-1:0] REG_MASK1 = 3'd4;
  localparam logic [CFG_ADDR_W-1:0] REG_ATTR1 = 3'd5;

  // Attribute bits
  localparam int ATTR_EN_BIT  = 0;
  localparam int ATTR_BUF_BIT = 1;

  ////////////////////////////////////////////////////////////
  // Request and buffer types
  ////////////////////////////////////////////////////////////
  // Core request after attribute lookup, 71 bits
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
    // Bit 0 set means bufferable
    logic [1:0]        memtype;
  } dwb_req_t;

  typedef enum logic {
    WBUF_EMPTY = 1'b0,
    WBUF_FULL  = 1'b1
  } wbuf_state_e;

endpackage

`default_nettype wire

/* hdl/dwb_region_cfg.sv */
`timescale 1ns/100ps
`default_nettype none

module dwb_region_cfg
  import dwb_pkg::*;
(
  input  wire                                    clk,
  input  wire                                    rst_n,
  // Wishbone classic slave
  input  logic                                   cfg_cyc_i,
  input  logic                                   cfg_stb_i,
  input  logic                                   cfg_we_i,
  input  logic [CFG_ADDR_W-1:0]                  cfg_adr_i,
  input  logic [DATA_W-1:0]                      cfg_dat_i,
  output logic [DATA_W-1:0]                      cfg_dat_o,
  output logic                                   cfg_ack_o,
  // Region table toward the checker
  output logic [NUM_REGIONS-1:0][ADDR_W-1:0]     region_base_o,
  output logic [NUM_REGIONS-1:0][ADDR_W-1:0]     region_mask_o,
  output logic [NUM_REGIONS-1:0][ATTR_W-1:0]     region_attr_o
);

  logic                                  ack_q;
  logic                                  cfg_access;
  logic                                  cfg_wr;
  logic [DATA_W-1:0]                     rd_data;
  logic [NUM_REGIONS-1:0][ADDR_W-1:0]    base_q;
  logic [NUM_REGIONS-1:0][ADDR_W-1:0]    mask_q;
  logic [NUM_REGIONS-1:0][ATTR_W-1:0]    attr_q;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////
  // New access seen, not yet acknowledged
  assign cfg_access = cfg_cyc_i && cfg_stb_i && !ack_q;
  assign cfg_wr     = cfg_access && cfg_we_i;

  // Single cycle ack, one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= cfg_access;
    end
  end

  ////////////////////////////////////////////////////////////
  // Region registers
  ////////////////////////////////////////////////////////////
  // Cleared at reset so that no region is enabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      base_q <= '0;
      mask_q <= '0;
      attr_q <= '0;
    end else if (cfg_wr) begin
      case (cfg_adr_i)
        REG_BASE0: base_q[0] <= cfg_dat_i;
        REG_MASK0: mask_q[0] <= cfg_dat_i;
        REG_ATTR0: attr_q[0] <= cfg_dat_i[ATTR_W-1:0];
        REG_BASE1: base_q[1] <= cfg_dat_i;
        REG_MASK1: mask_q[1] <= cfg_dat_i;
        REG_ATTR1: attr_q[1] <= cfg_dat_i[ATTR_W-1:0];
        default: ;
      endcase
    end
  end

  // Read mux, unused offsets give zero
  always_comb begin
    rd_data = '0;
    case (cfg_adr_i)
      REG_BASE0: rd_data = base_q[0];
      REG_MASK0: rd_data = mask_q[0];
      REG_ATTR0: rd_data = {{(DATA_W-ATTR_W){1'b0}}, attr_q[0]};
      REG_BASE1: rd_data = base_q[1];
      REG_MASK1: rd_data = mask_q[1];
      REG_ATTR1: rd_data = {{(DATA_W-ATTR_W){1'b0}}, attr_q[1]};
      default:   rd_data = '0;
    endcase
  end

  // Read data valid together with the ack
  always_ff @(posedge clk) begin
    if (cfg_access) begin
      cfg_dat_o <= rd_data;
    end
  end

  assign cfg_ack_o     = ack_q;
  assign region_base_o = base_q;
  assign region_mask_o = mask_q;
  assign region_attr_o = attr_q;

  // Master must see a fresh strobe before the next ack
  a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_ack_o |=> !cfg_ack_o);

endmodule

`default_nettype wire

/* hdl/dwb_attr_check.sv */
`timescale 1ns/100ps
`default_nettype none

module dwb_attr_check
  import dwb_pkg::*;
(
  // Core request fields
  input  logic                                lsu_we_i,
  input  logic [ADDR_W-1:0]                   lsu_addr_i,
  input  logic [DATA_W-1:0]                   lsu_wdata_i,
  input  logic [BE_W-1:0]                     lsu_be_i,
  // Region table
  input  logic [NUM_REGIONS-1:0][ADDR_W-1:0]  region_base_i,
  input  logic [NUM_REGIONS-1:0][ADDR_W-1:0]  region_mask_i,
  input  logic [NUM_REGIONS-1:0][ATTR_W-1:0]  region_attr_i,
  // Request with memtype filled in
  output dwb_req_t                            req_o
);

  logic [NUM_REGIONS-1:0] region_hit;
  logic                   hit_bufferable;

  ////////////////////////////////////////////////////////////
  // Region match
  ////////////////////////////////////////////////////////////
  // Hit when enabled and masked address equals the base
  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_match
    assign region_hit[i] = region_attr_i[i][ATTR_EN_BIT] &&
                           ((lsu_addr_i & region_mask_i[i]) == region_base_i[i]);
  end

  // Walk from the top so the lowest region wins
  always_comb begin
    hit_bufferable = 1'b0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_hit[i]) begin
        hit_bufferable = region_attr_i[i][ATTR_BUF_BIT];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Request assembly
  ////////////////////////////////////////////////////////////
  assign req_o.we    = lsu_we_i;
  assign req_o.addr  = lsu_addr_i;
  assign req_o.wdata = lsu_wdata_i;
  assign req_o.be    = lsu_be_i;
  // Only writes may be buffered, bit 1 is reserved
  assign req_o.memtype = {1'b0, lsu_we_i && hit_bufferable};

endmodule

`default_nettype wire

/* hdl/dwb_write_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module dwb_write_buffer
  import dwb_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  // Upstream, from the checker
  input  logic     valid_i,
  input  dwb_req_t trans_i,
  // Downstream, toward the bus master
  input  logic     ready_i,
  output logic     valid_o,
  output dwb_req_t trans_o,
  // Upstream ready
  output logic     ready_o
);

  wbuf_state_e state_q;
  wbuf_state_e state_d;
  dwb_req_t    trans_q;
  logic        push;
  logic        bufferable;
  logic        full;

  assign bufferable = trans_i.memtype[0];
  assign full       = (state_q == WBUF_FULL);

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    push    = 1'b0;
    case (state_q)
      WBUF_EMPTY: begin
        // Park a bufferable write the bus cannot take now
        if (valid_i && bufferable && !ready_i) begin
          push    = 1'b1;
          state_d = WBUF_FULL;
        end
      end
      WBUF_FULL: begin
        // Stored word leaves when downstream takes it
        if (ready_i) begin
          if (valid_i && bufferable) begin
            // Refill in the same cycle
            push = 1'b1;
          end else begin
            state_d = WBUF_EMPTY;
          end
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (push) begin
      trans_q <= trans_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////
  // Stored word goes first, otherwise pass through
  assign valid_o = full || valid_i;
  assign trans_o = full ? trans_q : trans_i;

  // Full: only a bufferable write, and only as the slot frees up
  // Empty: any request the bus takes, or a write we can park
  assign ready_o = full ? (bufferable && ready_i) : (bufferable || ready_i);

  // Stored word held steady toward a stalled bus master
  a_hold_full: assert property (@(posedge clk) disable iff (!rst_n)
    (full && !ready_i) |=> (valid_o && $stable(trans_o)));

endmodule

`default_nettype wire

/* hdl/dwb_bus_master.sv */
`timescale 1ns/100ps
`default_nettype none

module dwb_bus_master
  import dwb_pkg::*;
(
  input  wire               clk,
  input  wire               rst_n,
  // Request from the write buffer
  input  logic              valid_i,
  input  dwb_req_t          trans_i,
  output logic              ready_o,
  // Wishbone classic master
  output logic              mem_cyc_o,
  output logic              mem_stb_o,
  output logic              mem_we_o,
  output logic [ADDR_W-1:0] mem_adr_o,
  output logic [DATA_W-1:0] mem_dat_o,
  output logic [BE_W-1:0]   mem_sel_o,
  input  logic [DATA_W-1:0] mem_dat_i,
  input  logic              mem_ack_i,
  // In-order response
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  logic              cyc_q;
  logic              stb_q;
  logic              we_q;
  logic [ADDR_W-1:0] adr_q;
  logic [DATA_W-1:0] dat_q;
  logic [BE_W-1:0]   sel_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic              accept;
  logic              done;

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////
  // One cycle at a time, new request only when idle
  assign ready_o = !cyc_q;
  assign accept  = valid_i && ready_o;
  assign done    = cyc_q && mem_ack_i;

  ////////////////////////////////////////////////////////////
  // Bus cycle control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc_q    <= 1'b0;
      stb_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // Response pulse in the cycle after ack
      rvalid_q <= done;
      if (accept) begin
        cyc_q <= 1'b1;
        stb_q <= 1'b1;
      end else if (done) begin
        cyc_q <= 1'b0;
        stb_q <= 1'b0;
      end
    end
  end

  // Request fields held for the whole cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      we_q  <= trans_i.we;
      adr_q <= trans_i.addr;
      dat_q <= trans_i.wdata;
      sel_q <= trans_i.be;
    end
  end

  // Read data captured on ack, writes answer with zero
  always_ff @(posedge clk) begin
    if (done) begin
      rdata_q <= we_q ? '0 : mem_dat_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////
  assign mem_cyc_o = cyc_q;
  assign mem_stb_o = stb_q;
  assign mem_we_o  = we_q;
  assign mem_adr_o = adr_q;
  assign mem_dat_o = dat_q;
  assign mem_sel_o = sel_q;
  assign rvalid_o  = rvalid_q;
  assign rdata_o   = rdata_q;

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    mem_stb_o |-> mem_cyc_o);

endmodule

`default_nettype wire

/* hdl/dwb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dwb_top
  import dwb_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst_n,
  // Core request
  input  logic                  lsu_valid_i,
  input  logic                  lsu_we_i,
  input  logic [ADDR_W-1:0]     lsu_addr_i,
  input  logic [DATA_W-1:0]     lsu_wdata_i,
  input  logic [BE_W-1:0]       lsu_be_i,
  output logic                  lsu_ready_o,
  // Core response
  output logic                  lsu_rvalid_o,
  output logic [DATA_W-1:0]     lsu_rdata_o,
  // Wishbone master toward memory
  output logic                  mem_cyc_o,
  output logic                  mem_stb_o,
  output logic                  mem_we_o,
  output logic [ADDR_W-1:0]     mem_adr_o,
  output logic [DATA_W-1:0]     mem_dat_o,
  output logic [BE_W-1:0]       mem_sel_o,
  input  logic [DATA_W-1:0]     mem_dat_i,
  input  logic                  mem_ack_i,
  // Wishbone slave for the region table
  input  logic                  cfg_cyc_i,
  input  logic                  cfg_stb_i,
  input  logic                  cfg_we_i,
  input  logic [CFG_ADDR_W-1:0] cfg_adr_i,
  input  logic [DATA_W-1:0]     cfg_dat_i,
  output logic [DATA_W-1:0]     cfg_dat_o,
  output logic                  cfg_ack_o
);

  logic [NUM_REGIONS-1:0][ADDR_W-1:0] region_base;
  logic [NUM_REGIONS-1:0][ADDR_W-1:0] region_mask;
  logic [NUM_REGIONS-1:0][ATTR_W-1:0] region_attr;
  dwb_req_t                           chk_req;
  logic                               wbuf_valid;
  dwb_req_t                           wbuf_trans;
  logic                               bm_ready;

  ////////////////////////////////////////////////////////////
  // Region table and lookup
  ////////////////////////////////////////////////////////////
  dwb_region_cfg u_region_cfg (
    .clk           (clk),
    .rst_n         (rst_n),
    .cfg_cyc_i     (cfg_cyc_i),
    .cfg_stb_i     (cfg_stb_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_adr_i     (cfg_adr_i),
    .cfg_dat_i     (cfg_dat_i),
    .cfg_dat_o     (cfg_dat_o),
    .cfg_ack_o     (cfg_ack_o),
    .region_base_o (region_base),
    .region_mask_o (region_mask),
    .region_attr_o (region_attr)
  );

  dwb_attr_check u_attr_check (
    .lsu_we_i      (lsu_we_i),
    .lsu_addr_i    (lsu_addr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_be_i      (lsu_be_i),
    .region_base_i (region_base),
    .region_mask_i (region_mask),
    .region_attr_i (region_attr),
    .req_o         (chk_req)
  );

  ////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////
  // Core valid goes straight to the buffer
  dwb_write_buffer u_write_buffer (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_i (lsu_valid_i),
    .trans_i (chk_req),
    .ready_i (bm_ready),
    .valid_o (wbuf_valid),
    .trans_o (wbuf_trans),
    .ready_o (lsu_ready_o)
  );

  dwb_bus_master u_bus_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (wbuf_valid),
    .trans_i   (wbuf_trans),
    .ready_o   (bm_ready),
    .mem_cyc_o (mem_cyc_o),
    .mem_stb_o (mem_stb_o),
    .mem_we_o  (mem_we_o),
    .mem_adr_o (mem_adr_o),
    .mem_dat_o (mem_dat_o),
    .mem_sel_o (mem_sel_o),
    .mem_dat_i (mem_dat_i),
    .mem_ack_i (mem_ack_i),
    .rvalid_o  (lsu_rvalid_o),
    .rdata_o   (lsu_rdata_o)
  );

endmodule

`default_nettype wire

/* dv/dwb_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dwb_tb
  import dwb_pkg::*;
;

  localparam int MAX_LINES = 64;
  localparam int COLS      = 6;

  logic                  clk;
  logic                  rst_n;
  logic                  lsu_valid_i;
  logic                  lsu_we_i;
  logic [ADDR_W-1:0]     lsu_addr_i;
  logic [DATA_W-1:0]     lsu_wdata_i;
  logic [BE_W-1:0]       lsu_be_i;
  logic                  lsu_ready_o;
  logic                  lsu_rvalid_o;
  logic [DATA_W-1:0]     lsu_rdata_o;
  logic                  mem_cyc_o;
  logic                  mem_stb_o;
  logic                  mem_we_o;
  logic [ADDR_W-1:0]     mem_adr_o;
  logic [DATA_W-1:0]     mem_dat_o;
  logic [BE_W-1:0]       mem_sel_o;
  logic [DATA_W-1:0]     mem_dat_i;
  logic                  mem_ack_i;
  logic                  cfg_cyc_i;
  logic                  cfg_stb_i;
  logic                  cfg_we_i;
  logic [CFG_ADDR_W-1:0] cfg_adr_i;
  logic [DATA_W-1:0]     cfg_dat_i;
  logic [DATA_W-1:0]     cfg_dat_o;
  logic                  cfg_ack_o;

  logic [31:0] stim [0:MAX_LINES*COLS-1];
  logic [31:0] mem_words [0:255];
  logic [31:0] exp_q [$];
  string       name_q [$];
  int          outstanding;
  int          n_lines;
  integer      seed = 89;

  dwb_top dut0 (.*);

  // 8 ns clock
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Failure reporting
  ////////////////////////////////////////////////////////////
  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v === exp_v) else
      stop_on_failure($sformatf("Error: %s expected %h actual %h", name, exp_v, act_v));
  endtask

  ////////////////////////////////////////////////////////////
  // Wishbone memory model
  ////////////////////////////////////////////////////////////
  // Registered ack after 0 to 3 extra wait states
  always begin : mem_model
    logic        busy;
    logic [31:0] wait_cnt;
    logic [31:0] word;
    logic        req;
    busy = 1'b0;
    wait_cnt = '0;
    forever begin
      @(posedge clk);
      #1;
      req = mem_cyc_o && mem_stb_o && !mem_ack_i;
      mem_ack_i = 1'b0;
      if (!rst_n) begin
        busy = 1'b0;
      end else if (busy) begin
        if (wait_cnt == 0) begin
          busy = 1'b0;
          assert (mem_adr_o[ADDR_W-1:10] == '0) else
            stop_on_failure($sformatf("memory access outside the model at %h", mem_adr_o));
          word = mem_words[mem_adr_o[9:2]];
          if (mem_we_o) begin
            // Merge the selected bytes
            for (int b = 0; b < BE_W; b++) begin
              if (mem_sel_o[b]) begin
                word[8*b +: 8] = mem_dat_o[8*b +: 8];
              end
            end
            mem_words[mem_adr_o[9:2]] = word;
          end
          mem_dat_i = word;
          mem_ack_i = 1'b1;
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end else if (req) begin
        busy = 1'b1;
        wait_cnt = $unsigned($random(seed)) % 4;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////
  // Registered rvalid pulse is sampled once at the falling edge
  always @(negedge clk) begin : resp_monitor
    logic [31:0] exp_v;
    string       exp_name;
    if (rst_n && lsu_rvalid_o) begin
      assert (exp_q.size() > 0 && outstanding > 0) else
        stop_on_failure("response pulse without an outstanding request");
      exp_v = exp_q.pop_front();
      exp_name = name_q.pop_front();
      outstanding = outstanding - 1;
      check_value({exp_name, " response"}, exp_v, lsu_rdata_o);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks entered 1 ns after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic drain_bus();
    while (outstanding != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic cfg_access(input string name, input logic [31:0] op,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_v);
    logic [31:0] rd;
    cfg_cyc_i = 1'b1;
    cfg_stb_i = 1'b1;
    cfg_we_i  = (op == 0);
    cfg_adr_i = addr[CFG_ADDR_W-1:0];
    cfg_dat_i = data;
    @(negedge clk);
    while (!cfg_ack_o) begin
      @(negedge clk);
    end
    rd = cfg_dat_o;
    @(posedge clk);
    #1;
    cfg_cyc_i = 1'b0;
    cfg_stb_i = 1'b0;
    cfg_we_i  = 1'b0;
    if (op == 1) begin
      check_value(name, exp_v, rd);
    end
  endtask

  task automatic mem_access(input string name, input logic [31:0] op,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] be, input logic [31:0] exp_v,
                            input logic [31:0] stall);
    logic accepted;
    logic stalled;
    accepted = 1'b0;
    stalled  = 1'b0;
    lsu_valid_i = 1'b1;
    lsu_we_i    = (op == 2);
    lsu_addr_i  = addr;
    lsu_wdata_i = data;
    lsu_be_i    = be[BE_W-1:0];
    while (!accepted) begin
      @(negedge clk);
      if (lsu_ready_o) begin
        accepted = 1'b1;
      end else if (mem_cyc_o) begin
        // Held off while the bus master is busy
        stalled = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    lsu_valid_i = 1'b0;
    outstanding = outstanding + 1;
    // Writes answer with zero data
    exp_q.push_back((op == 2) ? 32'h0 : exp_v);
    name_q.push_back(name);
    check_value({name, " stall"}, stall, {31'b0, stalled});
  endtask

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////
  initial begin : watchdog
    wait (n_lines > 0);
    repeat (n_lines * 20) @(posedge clk);
    $display("Timeout after %0d cycles, DUT stopped responding", n_lines * 20);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    string name;
    logic [31:0] op;
    clk = 1'b0;
    rst_n = 1'b0;
    lsu_valid_i = 1'b0;
    lsu_we_i = 1'b0;
    lsu_addr_i = '0;
    lsu_wdata_i = '0;
    lsu_be_i = '0;
    mem_dat_i = '0;
    mem_ack_i = 1'b0;
    cfg_cyc_i = 1'b0;
    cfg_stb_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_adr_i = '0;
    cfg_dat_i = '0;
    outstanding = 0;
    n_lines = 0;
    // Fill pattern follows the byte address
    for (int i = 0; i < 256; i++) begin
      mem_words[i] = 32'hC0DE0000 | (i << 2);
    end
    for (int i = 0; i < MAX_LINES*COLS; i++) begin
      stim[i] = '1;
    end
    $readmemh("dv/dwb_input.txt", stim);
    while (n_lines < MAX_LINES && stim[n_lines*COLS] != 32'hFFFFFFFF) begin
      n_lines = n_lines + 1;
    end
    assert (n_lines > 0) else stop_on_failure("no stimulus lines read from dv/dwb_input.txt");

    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < n_lines; i++) begin
      op = stim[i*COLS];
      name = $sformatf("line %0d op %0d addr %h", i, op, stim[i*COLS+1]);
      if (op < 2) begin
        // Region table only changes with the bus quiet
        drain_bus();
        cfg_access(name, op, stim[i*COLS+1], stim[i*COLS+2], stim[i*COLS+4]);
      end else begin
        mem_access(name, op, stim[i*COLS+1], stim[i*COLS+2], stim[i*COLS+3],
                   stim[i*COLS+4], stim[i*COLS+5]);
      end
    end
    drain_bus();
    repeat (3) @(posedge clk);

    if (outstanding == 0 && exp_q.size() == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("Error: end of run expected 0 outstanding actual %0d", outstanding);
      $display("tests failed");
      $fatal(1, "responses missing at end of run");
    end
  end

endmodule

`default_nettype wire

/* dwb.f */
hdl/dwb_pkg.sv
hdl/dwb_region_cfg.sv
hdl/dwb_attr_check.sv
hdl/dwb_write_buffer.sv
hdl/dwb_bus_master.sv
hdl/dwb_top.sv
dv/dwb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the write-buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  -f dwb.f \
  --top-module dwb_tb \
  -o Vdwb_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vdwb_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

/* dv/dwb_input.txt */
// Columns: op (0 cfg wr, 1 cfg rd, 2 mem wr, 3 mem rd), address, data, byte enables,
// expected value, expected stall (1 = ready low while the bus is busy before acceptance)
0 00000000 00000000 0 00000000 0
0 00000001 FFFFFF00 0 00000000 0
0 00000002 FFFFFFFF 0 00000000 0
0 00000003 00000100 0 00000000 0
0 00000004 FFFFFF00 0 00000000 0
0 00000005 00000001 0 00000000 0
0 00000006 12345678 0 00000000 0
1 00000000 00000000 0 00000000 0
1 00000001 00000000 0 FFFFFF00 0
1 00000002 00000000 0 00000003 0
1 00000003 00000000 0 00000100 0
1 00000005 00000000 0 00000001 0
1 00000006 00000000 0 00000000 0
1 00000007 00000000 0 00000000 0
2 00000010 11223344 F 00000000 0
2 00000014 55667788 F 00000000 0
2 00000018 AABBCCDD 3 00000000 1
3 00000014 00000000 0 55667788 1
3 00000018 00000000 0 C0DECCDD 1
2 00000110 01020304 F 00000000 1
2 00000210 0A0B0C0D C 00000000 1
3 00000110 00000000 0 01020304 1
3 00000210 00000000 0 0A0B0210 1
3 00000020 00000000 0 C0DE0020 1
0 00000005 00000003 0 00000000 0
2 00000120 DEADBEEF F 00000000 0
2 00000124 000000EE 1 00000000 0
3 00000124 00000000 0 C0DE01EE 1
3 00000120 00000000 0 DEADBEEF 1
0 00000003 00000000 0 00000000 0
0 00000004 00000000 0 00000000 0
0 00000005 00000001 0 00000000 0
3 00000020 00000000 0 C0DE0020 0
2 00000030 5A5A5A5A F 00000000 0
2 00000150 13579BDF F 00000000 1
3 00000030 00000000 0 5A5A5A5A 1
3 00000150 00000000 0 13579BDF 1
